//--- hdl/countdown_display.sv
`timescale 1ns/1ps

module countdown_display (
	input  logic       CLK,
	input  logic       reset,
	input  logic       timer_tick,
	input  logic       scan_tick,
	output logic [6:0] seg,
	output logic [3:0] an
);
	import whack_pkg::*;

	localparam int PW = $clog2(MUX_DIV + 1);

	logic [3:0]    tens;
	logic [3:0]    units;
	logic [PW-1:0] pre;
	logic [1:0]    slot;
	logic [3:0]    digit;

	// gfedcba, active low
	function automatic logic [6:0] seg_code(input logic [3:0] d);
		case (d)
			4'd0: seg_code = 7'b1000000;
			4'd1: seg_code = 7'b1111001;
			4'd2: seg_code = 7'b0100100;
			4'd3: seg_code = 7'b0110000;
			4'd4: seg_code = 7'b0011001;
			4'd5: seg_code = 7'b0010010;
			4'd6: seg_code = 7'b0000010;
			4'd7: seg_code = 7'b1111000;
			4'd8: seg_code = 7'b0000000;
			4'd9: seg_code = 7'b0010000;
			default: seg_code = 7'b0111111;   // dash
		endcase
	endfunction

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			tens  <= 4'd9;
			units <= 4'd9;
		end
		else if (timer_tick)
		begin
			if (units == 4'd0)
			begin
				units <= 4'd9;
				tens  <= (tens == 4'd0) ? 4'd9 : tens - 1'b1;   // 00 wraps to 99
			end
			else
				units <= units - 1'b1;
		end
	end

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			pre  <= '0;
			slot <= 2'd0;
		end
		else if (scan_tick)
		begin
			if (pre == PW'(MUX_DIV - 1))
			begin
				pre  <= '0;
				slot <= slot + 1'b1;
			end
			else
				pre <= pre + 1'b1;
		end
	end

	// upper two slots fall through to the dash code
	assign digit = (slot == 2'd0) ? units : (slot == 2'd1) ? tens : 4'hf;
	assign seg   = seg_code(digit);
	assign an    = ~(4'b0001 << slot);

endmodule

//--- hdl/matrix_scan.sv
`timescale 1ns/1ps

module matrix_scan (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic                        scan_tick,
	input  whack_pkg::level_e           level,
	input  logic                        won,
	input  logic [7:0]                  mole_row,
	output logic [whack_pkg::ROW_W-1:0] row,
	output logic [3:0]                  com,
	output logic [7:0]                  data_r,
	output logic [7:0]                  data_g,
	output logic [7:0]                  data_b
);
	import whack_pkg::*;

	logic [ROW_W-1:0] row_q;
	logic [ROW_W-1:0] row_nx;

	assign row_nx = (row_q == ROW_W'(ROWS - 1)) ? '0 : row_q + 1'b1;

	// request the row that goes out on the next scan tick
	assign row = row_nx;

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			row_q  <= '0;
			com    <= 4'b1000;
			data_r <= '1;
			data_g <= '1;
			data_b <= '1;
		end
		else if (scan_tick)
		begin
			row_q <= row_nx;
			com   <= {1'b1, row_nx};
			if (won)
			begin
				data_r <= '0;   // whole matrix lit
				data_g <= '0;
				data_b <= '0;
			end
			else
			begin
				data_r <= mole_row;
				data_b <= (level != LEVEL1) ? mole_row : 8'hff;
				data_g <= (level == LEVEL3) ? mole_row : 8'hff;
			end
		end
	end

endmodule

//--- hdl/mole_sequencer.sv
`timescale 1ns/1ps

module mole_sequencer (
	input  logic                         CLK,
	input  logic                         reset,
	input  logic                         mole_tick,
	input  logic                         won,
	input  logic [whack_pkg::CELL_W-1:0] sw,
	input  logic [whack_pkg::ROW_W-1:0]  row,
	output logic                         hit,
	output logic                         beep,
	output logic [7:0]                   mole_row
);
	import whack_pkg::*;

	logic [CELL_W-1:0] pos;
	logic [CELL_W-1:0] pos_next;
	logic              flash;
	logic              match;
	logic [7:0]        row_bits;

	assign pos_next = CELL_W'(LCG_MUL * pos + LCG_ADD);
	assign match    = !won && (sw == pos);

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			pos   <= '0;
			flash <= 1'b0;
			hit   <= 1'b0;
		end
		else
		begin
			hit <= mole_tick && match;   // single cycle pulse
			if (mole_tick)
			begin
				pos   <= pos_next;   // moves whether hit or not
				flash <= match;      // held until next mole tick
			end
		end
	end

	// beep and the blanked frame share the same flag
	assign beep = flash;

	// low pos bits pick the row pair, high bits the column pair
	always_comb
	begin
		row_bits = '1;
		if (!flash && row[2:1] == pos[1:0])
		begin
			row_bits[{pos[3:2], 1'b0}] = 1'b0;
			row_bits[{pos[3:2], 1'b1}] = 1'b0;
		end
	end

	always_ff @(posedge CLK)
	begin
		mole_row <= row_bits;
	end

endmodule

//--- hdl/score_keeper.sv
`timescale 1ns/1ps

module score_keeper (
	input  logic                          CLK,
	input  logic                          reset,
	input  logic                          hit,
	output logic [whack_pkg::SCORE_W-1:0] score,
	output whack_pkg::level_e             level,
	output logic                          won
);
	import whack_pkg::*;

	logic [SCORE_W-1:0] step;

	// bigger reward once the level goes up
	always_comb
	begin
		if (score < SCORE_W'(LEVEL2_SCORE))
			step = SCORE_W'(1);
		else if (score < SCORE_W'(LEVEL3_SCORE))
			step = SCORE_W'(2);
		else
			step = SCORE_W'(3);
	end

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			score <= '0;
			level <= LEVEL1;
			won   <= 1'b0;
		end
		else
		begin
			if (hit && !won)
				score <= score + step;   // frozen after a win
			won <= won || (score >= SCORE_W'(WIN_SCORE));
			if (score >= SCORE_W'(LEVEL3_SCORE))
				level <= LEVEL3;
			else if (score >= SCORE_W'(LEVEL2_SCORE))
				level <= LEVEL2;
			else
				level <= LEVEL1;
		end
	end

endmodule

//--- hdl/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 4
) (
	input  logic CLK,
	input  logic reset,
	output logic tick
);
	localparam int CW = $clog2(DIV);

	logic [CW-1:0] cnt;

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else if (cnt == CW'(DIV - 1))
		begin
			cnt  <= '0;
			tick <= 1'b1;   // one cycle per wrap
		end
		else
		begin
			cnt  <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

//--- hdl/whack_pkg.sv
package whack_pkg;

	// matrix geometry
	localparam int ROWS    = 8;
	localparam int ROW_W   = 3;
	localparam int CELL_W  = 4;   // 4x4 mole grid
	localparam int SCORE_W = 6;

	// strobe divisors in CLK cycles, small for simulation
	localparam int SCAN_DIV  = 4;
	localparam int MOLE_DIV  = 64;
	localparam int TIMER_DIV = 256;
	localparam int MUX_DIV   = 2;   // scan strobes per digit slot

	// next = (LCG_MUL * pos + LCG_ADD) mod 16
	localparam int LCG_MUL = 5;
	localparam int LCG_ADD = 3;

	// score thresholds
	localparam int LEVEL2_SCORE = 8;
	localparam int LEVEL3_SCORE = 20;
	localparam int WIN_SCORE    = 29;

	typedef enum logic [1:0] {
		LEVEL1 = 2'd1,
		LEVEL2 = 2'd2,
		LEVEL3 = 2'd3
	} level_e;

endpackage

//--- hdl/whack_top.sv
`timescale 1ns/1ps

module whack_top (
	input  logic                          CLK,
	input  logic                          reset,
	input  logic [whack_pkg::CELL_W-1:0]  sw,
	output logic                          beep,
	output logic [whack_pkg::SCORE_W-1:0] score,
	output whack_pkg::level_e             level,
	output logic [3:0]                    com,
	output logic [7:0]                    data_r,
	output logic [7:0]                    data_g,
	output logic [7:0]                    data_b,
	output logic [6:0]                    seg,
	output logic [3:0]                    an
);
	import whack_pkg::*;

	logic             scan_tick;
	logic             mole_tick;
	logic             timer_tick;
	logic             hit;
	logic             won;
	logic [ROW_W-1:0] row;
	logic [7:0]       mole_row;

	tick_gen #(.DIV(SCAN_DIV)) scan_div0 (
		.CLK   (CLK),
		.reset (reset),
		.tick  (scan_tick)
	);

	tick_gen #(.DIV(MOLE_DIV)) mole_div0 (
		.CLK   (CLK),
		.reset (reset),
		.tick  (mole_tick)
	);

	tick_gen #(.DIV(TIMER_DIV)) timer_div0 (
		.CLK   (CLK),
		.reset (reset),
		.tick  (timer_tick)
	);

	mole_sequencer mole_seq0 (
		.CLK       (CLK),
		.reset     (reset),
		.mole_tick (mole_tick),
		.won       (won),
		.sw        (sw),
		.row       (row),
		.hit       (hit),
		.beep      (beep),
		.mole_row  (mole_row)
	);

	score_keeper score0 (
		.CLK   (CLK),
		.reset (reset),
		.hit   (hit),
		.score (score),
		.level (level),
		.won   (won)
	);

	matrix_scan scan0 (
		.CLK       (CLK),
		.reset     (reset),
		.scan_tick (scan_tick),
		.level     (level),
		.won       (won),
		.mole_row  (mole_row),
		.row       (row),
		.com       (com),
		.data_r    (data_r),
		.data_g    (data_g),
		.data_b    (data_b)
	);

	countdown_display disp0 (
		.CLK        (CLK),
		.reset      (reset),
		.timer_tick (timer_tick),
		.scan_tick  (scan_tick),
		.seg        (seg),
		.an         (an)
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module whack_tb -o whack_sim -f src.f \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/whack_sim > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

//--- src.f
hdl/whack_pkg.sv
hdl/tick_gen.sv
hdl/mole_sequencer.sv
hdl/score_keeper.sv
hdl/matrix_scan.sv
hdl/countdown_display.sv
hdl/whack_top.sv
verif/whack_chk.sv
verif/whack_tb.sv

//--- verif/whack_chk.sv
`timescale 1ns/1ps

module whack_chk (
	input logic                          CLK,
	input logic                          reset,
	input logic [3:0]                    com,
	input whack_pkg::level_e             level,
	input logic [whack_pkg::SCORE_W-1:0] score,
	input logic                          won
);
	import whack_pkg::*;

	// row select keeps its enable bit and moves one row at a time
	com_scan: assert property (@(posedge CLK) disable iff (reset)
		com[3] && (com[2:0] == $past(com[2:0]) || com[2:0] == $past(com[2:0]) + 3'd1))
	else
		$error("com lost its top bit or skipped a row");

	level_rises: assert property (@(posedge CLK) disable iff (reset) level >= $past(level))
	else
		$error("level went down");

	score_frozen: assert property (@(posedge CLK) disable iff (reset) won |=> $stable(score))
	else
		$error("score changed after the game was won");

endmodule

bind whack_top whack_chk chk0 (
	.CLK   (CLK),
	.reset (reset),
	.com   (com),
	.level (level),
	.score (score),
	.won   (won)
);

//--- verif/whack_tb.sv
`timescale 1ns/1ps

module whack_tb;
	import whack_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int MOLE_EVENTS = 32;   // upper bound on mole ticks used
	localparam int TEST_UNITS  = (MOLE_EVENTS * MOLE_DIV) / TIMER_DIV + 102;
	localparam int WATCHDOG_NS = TEST_UNITS * 3 / 2 * TIMER_DIV * CLK_PERIOD;

	logic               CLK;
	logic               reset;
	logic [CELL_W-1:0]  sw;
	logic               beep;
	logic [SCORE_W-1:0] score;
	level_e             level;
	logic [3:0]         com;
	logic [7:0]         data_r;
	logic [7:0]         data_g;
	logic [7:0]         data_b;
	logic [6:0]         seg;
	logic [3:0]         an;

	int                cyc;   // rising edges since reset release
	int                mole_k;
	int                errors;
	int                checks;
	int                tests;
	int                test_err;
	logic [31:0]       lfsr;
	logic [CELL_W-1:0] exp_pos;
	int                exp_score;
	logic              exp_won;

	whack_top dut0 (
		.CLK    (CLK),
		.reset  (reset),
		.sw     (sw),
		.beep   (beep),
		.score  (score),
		.level  (level),
		.com    (com),
		.data_r (data_r),
		.data_g (data_g),
		.data_b (data_b),
		.seg    (seg),
		.an     (an)
	);

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	task automatic verify(input logic ok, input string msg);
		checks++;
		assert (ok)
		else
		begin
			errors++;
			$display("Mismatch at %0t ns: %s", $time, msg);
		end
	endtask

	task automatic advance_to(input int n);
		while (cyc < n)
		begin
			@(posedge CLK);
			cyc++;
		end
	endtask

	// level number doubles as the score increment
	function automatic int level_for(input int s);
		return (s < LEVEL2_SCORE) ? 1 : (s < LEVEL3_SCORE) ? 2 : 3;
	endfunction

	// active low 2x2 block per grid cell
	function automatic logic [7:0] frame_row(input logic [3:0] p, input logic [2:0] r);
		logic [7:0] bits;
		logic [2:0] col;
		bits = 8'hff;
		col  = 3'(2 * (int'(p) / 4));
		if ((int'(r) / 2) == (int'(p) % 4))
		begin
			bits[col]        = 1'b0;
			bits[col + 3'd1] = 1'b0;
		end
		return bits;
	endfunction

	// gfedcba active low, anything outside 0..9 is a dash
	function automatic logic [6:0] seg_for(input int d);
		case (d)
			0: return 7'h40;
			1: return 7'h79;
			2: return 7'h24;
			3: return 7'h30;
			4: return 7'h19;
			5: return 7'h12;
			6: return 7'h02;
			7: return 7'h78;
			8: return 7'h00;
			9: return 7'h10;
			default: return 7'h3f;
		endcase
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		logic fb;
		v = '0;
		repeat (n)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
	endtask

	task automatic pick_miss(input logic [3:0] p, output logic [3:0] v);
		logic [31:0] r;
		do
		begin
			draw_bits(4, r);
			v = r[3:0];
		end
		while (v == p);
	endtask

	// one mole tick, then eight scan rows while the frame holds
	task automatic play_mole(input logic strike);
		int         m;
		int         i;
		int         lvl;
		logic [3:0] v;
		logic       exp_hit;
		logic [2:0] r;
		logic [7:0] exp_r;
		logic [7:0] seen;
		mole_k++;
		m = mole_k * MOLE_DIV + 1;
		if (strike)
			v = exp_pos;
		else
			pick_miss(exp_pos, v);
		advance_to(m - 1);
		sw <= v;
		exp_hit = strike && !exp_won;
		advance_to(m);
		@(negedge CLK);
		verify(beep == exp_hit, $sformatf("beep %b, expected %b at mole tick %0d",
			beep, exp_hit, mole_k));
		if (exp_hit)
			exp_score += level_for(exp_score);
		exp_won = (exp_score >= WIN_SCORE);
		exp_pos = CELL_W'((LCG_MUL * int'(exp_pos) + LCG_ADD) % 16);
		lvl     = level_for(exp_score);
		advance_to(m + 1);
		@(negedge CLK);
		verify(score == SCORE_W'(exp_score), $sformatf("score %0d, expected %0d",
			score, exp_score));
		seen = '0;
		for (i = 1; i <= ROWS; i++)
		begin
			advance_to(m + i * SCAN_DIV);
			@(negedge CLK);
			r       = com[2:0];
			seen[r] = 1'b1;
			exp_r   = exp_won ? 8'h00 : exp_hit ? 8'hff : frame_row(exp_pos, r);
			verify(data_r == exp_r, $sformatf("row %0d data_r %h, expected %h", r, data_r, exp_r));
			verify(data_b == ((exp_won || lvl >= 2) ? exp_r : 8'hff),
				$sformatf("row %0d data_b %h at level %0d", r, data_b, lvl));
			verify(data_g == ((exp_won || lvl == 3) ? exp_r : 8'hff),
				$sformatf("row %0d data_g %h at level %0d", r, data_g, lvl));
			verify(int'(level) == lvl, $sformatf("level %0d, expected %0d", level, lvl));
			verify(beep == exp_hit, $sformatf("beep %b changed between mole ticks", beep));
		end
		verify(seen == 8'hff, $sformatf("rows scanned %b, expected all eight", seen));
	endtask

	task automatic show_count(input int k);
		int         val;
		logic [3:0] seen;
		val = 99 - k % 100;
		advance_to(k * TIMER_DIV + 2);
		seen = '0;
		repeat (48)
		begin
			advance_to(cyc + 1);
			@(negedge CLK);
			case (an)
				4'b1110:
				begin
					seen[0] = 1'b1;
					verify(seg == seg_for(val % 10), $sformatf("units seg %b for %02d", seg, val));
				end
				4'b1101:
				begin
					seen[1] = 1'b1;
					verify(seg == seg_for(val / 10), $sformatf("tens seg %b for %02d", seg, val));
				end
				4'b1011:
				begin
					seen[2] = 1'b1;
					verify(seg == seg_for(-1), $sformatf("slot 2 seg %b, expected dash", seg));
				end
				4'b0111:
				begin
					seen[3] = 1'b1;
					verify(seg == seg_for(-1), $sformatf("slot 3 seg %b, expected dash", seg));
				end
				default: verify(1'b0, $sformatf("an %b selects no single digit", an));
			endcase
		end
		checks++;
		assert (seen == 4'hf)
		else
		begin
			errors++;
			$display("Not every digit slot was selected after timer tick %0d", k);
		end
	endtask

	task automatic reset_state();
		@(negedge CLK);
		verify(beep == 1'b0, "beep set after reset");
		verify(score == '0, $sformatf("score %0d after reset", score));
		verify(level == LEVEL1, $sformatf("level %0d after reset", level));
		verify(com == 4'b1000, $sformatf("com %b after reset", com));
		verify(data_r == 8'hff && data_g == 8'hff && data_b == 8'hff, "colours lit after reset");
		verify(an == 4'b1110, $sformatf("an %b after reset", an));
		verify(seg == seg_for(9), $sformatf("seg %b, expected 9", seg));
	endtask

	task automatic level_climb();
		while (exp_score < LEVEL2_SCORE && mole_k < MOLE_EVENTS)
			play_mole(1'b1);
		play_mole(1'b0);   // miss so the mole shows
		verify(level == LEVEL2 && data_b == data_r && data_g == 8'hff, "level 2 layering");
		while (exp_score < LEVEL3_SCORE && mole_k < MOLE_EVENTS)
			play_mole(1'b1);
		play_mole(1'b0);
		verify(level == LEVEL3 && data_b == data_r && data_g == data_r, "level 3 layering");
	endtask

	task automatic game_win();
		logic [SCORE_W-1:0] final_score;
		while (!exp_won && mole_k < MOLE_EVENTS)
			play_mole(1'b1);
		verify(score >= SCORE_W'(WIN_SCORE), $sformatf("score %0d short of a win", score));
		final_score = SCORE_W'(exp_score);
		play_mole(1'b1);
		play_mole(1'b1);
		verify(score == final_score, $sformatf("score %0d moved after the win", score));
	endtask

	task automatic report_test(input string name);
		$display("%-14s %s (%0d errors)", name, (errors == test_err) ? "ok" : "FAILED",
			errors - test_err);
		tests++;
		test_err = errors;
	endtask

	initial
	begin
		reset     = 1'b1;
		sw        = 4'hf;
		cyc       = 0;
		mole_k    = 0;
		errors    = 0;
		checks    = 0;
		tests     = 0;
		test_err  = 0;
		lfsr      = 32'h96b7b631;
		exp_pos   = '0;
		exp_score = 0;
		exp_won   = 1'b0;
		repeat (4) @(posedge CLK);
		reset <= 1'b0;
		reset_state();
		report_test("reset_state");
		repeat (3) play_mole(1'b0);
		report_test("mole_walk");
		play_mole(1'b1);
		play_mole(1'b0);
		report_test("hit_and_miss");
		level_climb();
		report_test("level_climb");
		game_win();
		report_test("game_win");
		show_count(cyc / TIMER_DIV + 1);
		show_count(99);   // reads 00
		show_count(100);  // wrapped back to 99
		report_test("countdown");
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
